/* Makefile */
TOP = tb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* data_memory.sv */
//////////////////////////////////////////////////////////////////////
// byte-addressed data memory model, tagged fixed-latency loads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "mem_config.svh"

module data_memory (
	input  logic               clock,
	input  logic               reset,
	input  mem_pkg::dmem_req_t req,
	output mem_pkg::dmem_rsp_t rsp
);

	localparam int IDX_W  = $clog2(`MEM_WORDS);
	localparam int NBYTES = `XLEN / 8;

	logic [`XLEN-1:0]  mem [`MEM_WORDS];
	logic [3:0]        tag_pipe  [`MEM_LATENCY]; // 0 = empty slot
	logic [`XLEN-1:0]  data_pipe [`MEM_LATENCY];
	logic [3:0]        tag_cnt;                  // next accept tag, 1..15
	logic [IDX_W-1:0]  word_idx;
	logic [1:0]        offset;
	logic [NBYTES-1:0] byte_en;
	logic [`XLEN-1:0]  wdata;
	logic              is_load;
	logic              is_store;

	assign word_idx = req.addr[IDX_W+1:2];
	assign offset   = req.addr[1:0];
	assign is_load  = (req.command == mem_pkg::BUS_LOAD);
	assign is_store = (req.command == mem_pkg::BUS_STORE);

	// byte lanes for a store, aligned accesses only
	always_comb begin
		case (req.size)
			mem_pkg::BYTE: byte_en = NBYTES'(4'b0001) << offset;
			mem_pkg::HALF: byte_en = NBYTES'(4'b0011) << offset;
			default:       byte_en = '1;
		endcase
		wdata = req.data << (8 * offset); // low bytes moved to their lanes
	end

	// array, cleared on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int w = 0; w < `MEM_WORDS; w++)
				mem[w] <= '0;
		end else if (is_store) begin
			for (int b = 0; b < NBYTES; b++)
				if (byte_en[b])
					mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
		end
	end

	// tag counter and tag pipe, skip 0 on wrap
	always_ff @(posedge clock) begin
		if (reset) begin
			tag_cnt <= 4'd1;
			for (int s = 0; s < `MEM_LATENCY; s++)
				tag_pipe[s] <= '0;
		end else begin
			if (is_load)
				tag_cnt <= (tag_cnt == 4'd15) ? 4'd1 : tag_cnt + 1'b1;
			tag_pipe[0] <= is_load ? tag_cnt : 4'd0;
			for (int s = 1; s < `MEM_LATENCY; s++)
				tag_pipe[s] <= tag_pipe[s-1];
		end
	end

	// load data, word read and shifted down by the byte offset
	always_ff @(posedge clock) begin
		data_pipe[0] <= mem[word_idx] >> (8 * offset);
		for (int s = 1; s < `MEM_LATENCY; s++)
			data_pipe[s] <= data_pipe[s-1];
	end

	assign rsp.response = is_load ? tag_cnt : 4'd0; // accept in request cycle
	assign rsp.tag      = tag_pipe[`MEM_LATENCY-1];
	assign rsp.data     = data_pipe[`MEM_LATENCY-1];

endmodule

`default_nettype wire

/* load_buffer.sv */
//////////////////////////////////////////////////////////////////////
// in-order load queue, oldest entry presented to the memory stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "mem_config.svh"

module load_buffer (
	input  logic                clock,
	input  logic                reset,
	input  mem_pkg::lb_packet_t dispatch_packet,
	input  logic                done,
	output mem_pkg::lb_packet_t head,
	output logic                full
);

	localparam int PTR_W = (`LB_DEPTH > 1) ? $clog2(`LB_DEPTH) : 1;
	localparam int CNT_W = $clog2(`LB_DEPTH + 1);

	mem_pkg::lb_packet_t entries [`LB_DEPTH]; // payload, no reset
	logic [PTR_W-1:0]    rd_ptr;
	logic [PTR_W-1:0]    wr_ptr;
	logic [CNT_W-1:0]    count;
	logic                push;
	logic                pop;
	logic                empty;

	// wrap at LB_DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`LB_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(`LB_DEPTH));
	assign push  = dispatch_packet.valid && !full; // dispatch holds off when full
	assign pop   = done && !empty;                 // writeback retires the head

	//////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle, or push and pop together
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clock) begin
		if (push)
			entries[wr_ptr] <= dispatch_packet;
	end

	// oldest entry, valid only while something is queued
	always_comb begin
		head       = entries[rd_ptr];
		head.valid = !empty;
	end

endmodule

`default_nettype wire

/* mem_config.svh */
//////////////////////////////////////////////////////////////////////
// build-time sizes for the memory back end
//////////////////////////////////////////////////////////////////////

`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`define XLEN        32 // data and address width
`define LB_DEPTH    4  // load buffer entries
`define MEM_WORDS   64 // data memory size in 32-bit words
`define MEM_LATENCY 3  // accepted load to returned tag and data

`endif

/* mem_pkg.sv */
//////////////////////////////////////////////////////////////////////
// bus, size and state enums plus the packets passed between
// load buffer, memory stage and data memory
//////////////////////////////////////////////////////////////////////

`default_nettype none
`include "mem_config.svh"

package mem_pkg;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'b00,
		BUS_LOAD  = 2'b01,
		BUS_STORE = 2'b10
	} bus_command_t;

	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} mem_size_t;

	// memory stage controller
	typedef enum logic {
		READY,
		MEM_WAIT
	} dmem_state_t;

	typedef struct packed {
		logic              valid;
		logic [`XLEN-1:0]  address;
		logic [2:0]        mem_size; // [2] unsigned, [1:0] size
		logic [3:0]        rd_tag;   // rob tag
	} lb_packet_t;

	typedef struct packed {
		logic              valid;
		logic              wr_mem;      // store commit
		logic [`XLEN-1:0]  mem_address;
		logic [2:0]        mem_size;
		logic [`XLEN-1:0]  data_out;
	} commit_packet_t;

	typedef struct packed {
		logic              valid;
		logic [3:0]        rob_tag;
		logic [`XLEN-1:0]  value;
	} ex_wr_packet_t;

	typedef struct packed {
		bus_command_t      command;
		mem_size_t         size;
		logic [`XLEN-1:0]  addr;
		logic [`XLEN-1:0]  data;
	} dmem_req_t;

	typedef struct packed {
		logic [3:0]        response; // accept tag, same cycle as request
		logic [3:0]        tag;      // completing tag, 0 = none
		logic [`XLEN-1:0]  data;
	} dmem_rsp_t;

endpackage

`default_nettype wire

/* mem_stage.sv */
//////////////////////////////////////////////////////////////////////
// memory stage: bus command select, outstanding load tracking,
// load data extension and writeback packet
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "mem_config.svh"

module mem_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  mem_pkg::lb_packet_t     head,
	input  mem_pkg::commit_packet_t cmt_packet,
	input  mem_pkg::dmem_rsp_t      rsp,
	output mem_pkg::dmem_req_t      req,
	output mem_pkg::ex_wr_packet_t  wb_packet
);

	mem_pkg::dmem_state_t  state;
	mem_pkg::dmem_state_t  next_state;
	mem_pkg::bus_command_t command;
	logic [3:0]            tag_q;     // tag of the load in flight
	logic                  load_issue;
	logic                  load_done;
	logic [`XLEN-1:0]      load_value;

	//////////////////////////////////////////////////////////////////////
	// stores always win the bus
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (cmt_packet.valid && cmt_packet.wr_mem)
			command = mem_pkg::BUS_STORE;
		else if (head.valid && state == mem_pkg::READY)
			command = mem_pkg::BUS_LOAD;
		else
			command = mem_pkg::BUS_NONE;
	end

	assign load_issue = (command == mem_pkg::BUS_LOAD);

	// size, address and data follow the chosen source
	always_comb begin
		req.command = command;
		if (load_issue) begin
			req.size = mem_pkg::mem_size_t'(head.mem_size[1:0]);
			req.addr = head.address;
			req.data = '0; // loads carry no data
		end else begin
			req.size = mem_pkg::mem_size_t'(cmt_packet.mem_size[1:0]);
			req.addr = cmt_packet.mem_address;
			req.data = cmt_packet.data_out;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// controller
	//////////////////////////////////////////////////////////////////////

	// waiting load completes when its own tag comes back
	assign load_done = (state == mem_pkg::MEM_WAIT) && (rsp.tag == tag_q);

	always_comb begin
		next_state = state;
		case (state)
			mem_pkg::READY:    if (load_issue) next_state = mem_pkg::MEM_WAIT;
			mem_pkg::MEM_WAIT: if (load_done) next_state = mem_pkg::READY;
			default:           next_state = mem_pkg::READY;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mem_pkg::READY;
			tag_q <= '0;
		end else begin
			state <= next_state;
			if (load_issue)
				tag_q <= rsp.response; // accept tag from the same cycle
		end
	end

	//////////////////////////////////////////////////////////////////////
	// load extension and writeback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (head.mem_size[1:0])
			2'b00: begin // byte
				if (head.mem_size[2])
					load_value = {{(`XLEN-8){1'b0}}, rsp.data[7:0]};
				else
					load_value = {{(`XLEN-8){rsp.data[7]}}, rsp.data[7:0]};
			end
			2'b01: begin // half
				if (head.mem_size[2])
					load_value = {{(`XLEN-16){1'b0}}, rsp.data[15:0]};
				else
					load_value = {{(`XLEN-16){rsp.data[15]}}, rsp.data[15:0]};
			end
			default: load_value = rsp.data; // word as is
		endcase
	end

	assign wb_packet.valid   = load_done; // one-cycle pulse
	assign wb_packet.rob_tag = head.rd_tag;
	assign wb_packet.value   = load_value;

endmodule

`default_nettype wire

/* mem_subsystem.sv */
//////////////////////////////////////////////////////////////////////
// top level: load buffer, memory stage and data memory model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_subsystem (
	input  logic                    clock,
	input  logic                    reset,
	input  mem_pkg::lb_packet_t     dispatch_packet,
	input  mem_pkg::commit_packet_t cmt_packet,
	output logic                    lb_full,
	output mem_pkg::ex_wr_packet_t  wb_packet
);

	mem_pkg::lb_packet_t lb_head; // oldest pending load
	mem_pkg::dmem_req_t  req;     // stage to memory
	mem_pkg::dmem_rsp_t  rsp;     // memory to stage

	// dispatched loads wait here in order
	load_buffer u_load_buffer (
		.clock           (clock),
		.reset           (reset),
		.dispatch_packet (dispatch_packet),
		.done            (wb_packet.valid), // writeback pops the head
		.head            (lb_head),
		.full            (lb_full)
	);

	mem_stage u_mem_stage (
		.clock      (clock),
		.reset      (reset),
		.head       (lb_head),
		.cmt_packet (cmt_packet),
		.rsp        (rsp),
		.req        (req),
		.wb_packet  (wb_packet)
	);

	data_memory u_data_memory (
		.clock (clock),
		.reset (reset),
		.req   (req),
		.rsp   (rsp)
	);

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mem_pkg.sv
load_buffer.sv
mem_stage.sv
data_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

/* tb_mem_subsystem.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the memory back end: stimulus, shadow memory,
// writeback checks and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "mem_config.svh"

module tb_mem_subsystem;

	localparam int CLOCK_PERIOD    = 20;
	localparam int BYTES           = 4 * `MEM_WORDS;
	localparam int IDX_W           = $clog2(`MEM_WORDS);
	localparam int RANDOM_OPS      = 200;
	localparam int MAX_LOADS       = 32 + RANDOM_OPS; // directed plus random
	localparam int MAX_STORES      = 20 + RANDOM_OPS;
	localparam int WATCHDOG_CYCLES = MAX_LOADS * (`MEM_LATENCY + 2 + MAX_STORES) + 1000;

	// mem_size codes with bit 2 set for unsigned
	localparam logic [2:0] SZ_B  = 3'b000;
	localparam logic [2:0] SZ_H  = 3'b001;
	localparam logic [2:0] SZ_W  = 3'b010;
	localparam logic [2:0] SZ_BU = 3'b100;
	localparam logic [2:0] SZ_HU = 3'b101;

	typedef logic [`XLEN-1:0] word_t;

	typedef struct packed {
		logic [3:0]       rob_tag;
		word_t            value;
		logic [IDX_W-1:0] word;    // keeps stores off pending loads
	} load_expect_t;

	logic                    clock;
	logic                    reset;
	mem_pkg::lb_packet_t     dispatch_packet;
	mem_pkg::commit_packet_t cmt_packet;
	logic                    lb_full;
	mem_pkg::ex_wr_packet_t  wb_packet;

	logic [7:0]   shadow [BYTES]; // mirror of data memory bytes
	load_expect_t exp_q [$];      // oldest load first
	load_expect_t front;
	logic [3:0]   next_rob;
	int           seed;

	mem_subsystem DUT (
		.clock           (clock),
		.reset           (reset),
		.dispatch_packet (dispatch_packet),
		.cmt_packet      (cmt_packet),
		.lb_full         (lb_full),
		.wb_packet       (wb_packet)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// reference model helpers
	//////////////////////////////////////////////////////////////////////

	function automatic int size_bytes(input logic [1:0] size);
		case (size)
			2'b00:   return 1;
			2'b01:   return 2;
			default: return 4;
		endcase
	endfunction

	// little endian load result built from the shadow bytes
	function automatic word_t expected_load(input word_t addr, input logic [2:0] msize);
		word_t raw;
		int    i;
		int    n;
		n   = size_bytes(msize[1:0]);
		raw = '0;
		for (i = 0; i < n; i++)
			raw[8*i +: 8] = shadow[int'(addr) + i];
		// signed narrow loads copy the top bit of the last byte upward
		if (!msize[2] && n < `XLEN / 8 && raw[8*n-1])
			for (i = n; i < `XLEN / 8; i++)
				raw[8*i +: 8] = 8'hFF;
		return raw;
	endfunction

	function automatic word_t random_address(input logic [1:0] size);
		word_t a;
		a = word_t'($unsigned($random(seed)) % BYTES);
		return a & ~word_t'(size_bytes(size) - 1); // aligned to size
	endfunction

	function automatic logic word_pending(input logic [IDX_W-1:0] w);
		foreach (exp_q[i])
			if (exp_q[i].word == w)
				return 1'b1;
		return 1'b0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// failure reporting and stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		$display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
			$time, name, got, exp);
		abort_run();
	endtask

	task automatic fail_with(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		abort_run();
	endtask

	// one-cycle store commit that updates the shadow at once
	task automatic commit_store(input word_t addr, input logic [2:0] msize, input word_t data);
		int i;
		cmt_packet.valid       = 1'b1;
		cmt_packet.wr_mem      = 1'b1;
		cmt_packet.mem_address = addr;
		cmt_packet.mem_size    = msize;
		cmt_packet.data_out    = data;
		for (i = 0; i < size_bytes(msize[1:0]); i++)
			shadow[int'(addr) + i] = data[8*i +: 8];
		@(negedge clock);
		cmt_packet = '0;
	endtask

	task automatic dispatch_load(input word_t addr, input logic [2:0] msize);
		load_expect_t e;
		while (lb_full)
			@(negedge clock); // hold off while the buffer is full
		e.rob_tag = next_rob;
		e.value   = expected_load(addr, msize);
		e.word    = addr[IDX_W+1:2];
		exp_q.push_back(e);
		dispatch_packet.valid    = 1'b1;
		dispatch_packet.address  = addr;
		dispatch_packet.mem_size = msize;
		dispatch_packet.rd_tag   = next_rob;
		next_rob = next_rob + 4'd1;
		@(negedge clock);
		dispatch_packet = '0;
	endtask

	task automatic drain_loads();
		while (exp_q.size() != 0)
			@(negedge clock);
	endtask

	// in-order writeback check against the expected queue
	always @(posedge clock) begin
		if (!reset && wb_packet.valid) begin
			assert (exp_q.size() != 0)
				else fail_with("writeback arrived with no load pending");
			front = exp_q.pop_front();
			assert (wb_packet.rob_tag == front.rob_tag)
				else report_mismatch("wb_packet.rob_tag", word_t'(wb_packet.rob_tag),
					word_t'(front.rob_tag));
			assert (wb_packet.value == front.value)
				else report_mismatch("wb_packet.value", wb_packet.value, front.value);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		fail_with($sformatf("watchdog timeout, %0d loads never written back", exp_q.size()));
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		word_t      a;
		word_t      d;
		logic [1:0] sz;
		int         op;
		clock           = 1'b0;
		reset           = 1'b1;
		dispatch_packet = '0;
		cmt_packet      = '0;
		seed            = 95007;
		next_rob        = 4'd1;
		for (op = 0; op < BYTES; op++)
			shadow[op] = 8'h00; // memory is cleared by reset
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		assert (!lb_full && !wb_packet.valid)
			else fail_with("lb_full or wb_packet.valid high after reset");

		dispatch_load(32'h10, SZ_W); // cleared word
		drain_loads();

		// byte lanes and store sizes
		commit_store(32'h20, SZ_W, 32'h1122_3344);
		commit_store(32'h21, SZ_B, 32'hFFFF_FFAB); // low byte only
		commit_store(32'h22, SZ_H, 32'h1234_BEEF);
		for (op = 0; op < 4; op++)
			commit_store(word_t'(32'h24 + op), SZ_B, word_t'(32'hC0 + op));
		commit_store(32'h28, SZ_H, 32'hAAAA_5678);
		commit_store(32'h2A, SZ_H, 32'h5555_9ABC);
		dispatch_load(32'h20, SZ_W);
		dispatch_load(32'h24, SZ_W);
		dispatch_load(32'h28, SZ_W);
		drain_loads();

		// top bits set in every byte and half
		commit_store(32'h30, SZ_W, 32'h9A85_F0C3);
		for (op = 0; op < 4; op++) begin
			dispatch_load(word_t'(32'h30 + op), SZ_B);
			dispatch_load(word_t'(32'h30 + op), SZ_BU);
		end
		for (op = 0; op < 2; op++) begin
			dispatch_load(word_t'(32'h30 + 2 * op), SZ_H);
			dispatch_load(word_t'(32'h30 + 2 * op), SZ_HU);
		end
		drain_loads();

		// fill the buffer back to back
		for (op = 0; op < `LB_DEPTH; op++)
			dispatch_load(word_t'(32'h20 + 4 * op), SZ_W);
		assert (lb_full)
			else fail_with("lb_full low after LB_DEPTH back-to-back loads");
		drain_loads();

		// store burst while loads wait
		for (op = 0; op < `LB_DEPTH; op++)
			dispatch_load(word_t'(32'h30 + 4 * op), SZ_W);
		for (op = 0; op < 6; op++)
			commit_store(word_t'(32'h40 + 4 * op), SZ_W, word_t'($random(seed)));
		drain_loads();
		dispatch_load(32'h40, SZ_W);
		dispatch_load(32'h4C, SZ_W);
		dispatch_load(32'h54, SZ_W);
		dispatch_load(32'h45, SZ_BU);
		drain_loads();

		// random mix against the shadow
		for (op = 0; op < RANDOM_OPS; op++) begin
			d  = word_t'($random(seed));
			sz = 2'($unsigned($random(seed)) % 3);
			if (d[0]) begin
				do
					a = random_address(sz);
				while (word_pending(a[IDX_W+1:2]));
				commit_store(a, {1'b0, sz}, word_t'($random(seed)));
			end else begin
				dispatch_load(random_address(sz), {d[31], sz});
			end
		end
		drain_loads();
		repeat (`MEM_LATENCY + 2) @(negedge clock); // room for a stray writeback

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
